// ==== Makefile ====
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f tb.f --top-module tb_vend -Mdir obj_dir -o Vtb_vend

run: compile
	./obj_dir/Vtb_vend | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tb.f ====
vend_pkg.sv
vend_buttons.sv
vend_select.sv
vend_credit.sv
vend_lcd_text.sv
vend_top.sv
tb_clock.sv
tb_vend.sv

// ==== tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release just after an edge, like the other inputs
    initial begin
        rst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b1;
    end

endmodule

// ==== tb_vend.sv ====
`timescale 1ns/1ns

module tb_vend import vend_pkg::*; ();

    localparam int REFUND_TICK      = 4;
    localparam int DIRECTED_PRESSES = 28;
    localparam int RANDOM_PRESSES   = 200;
    localparam int WATCHDOG_CYCLES  = (DIRECTED_PRESSES + RANDOM_PRESSES) * 10 + 2000;
    // clock edges taken by one press
    localparam int PRESS_CYCLES     = 6;

    localparam int BTN_COIN10 = 0;
    localparam int BTN_COIN5  = 1;
    localparam int BTN_COIN1  = 2;
    localparam int BTN_RETURN = 3;
    localparam int BTN_DOWN   = 4;
    localparam int BTN_SELECT = 7;
    localparam int BTN_BUY    = 9;
    localparam int BTN_UP     = 10;

    // return appears once in 16 to keep refunds short
    localparam int RANDOM_BUTTONS [16] = '{10, 4, 7, 0, 1, 2, 9, 3, 10, 4, 7, 9, 10, 4, 7, 9};

    typedef struct packed {
        money_t                  balance;
        stock_t [NUM_ITEMS-1:0]  stock;
        item_t                   sel;
        item_t                   cursor;
        logic                    window;
        logic [ADDR_W-1:0]       addr;
        line_t                   line1;
        line_t                   line2;
    } model_t;

    logic               clk;
    logic               rst;
    logic [11:0]        button_sw;
    money_t             money_display;
    stock_t             stock_1;
    stock_t             stock_2;
    stock_t             stock_3;
    item_t              selected_item;
    logic               refunding;
    line_t              line1_text;
    line_t              line2_text;
    logic [ADDR_W-1:0]  ddram_address;

    model_t       model;
    logic [15:0]  lfsr_state;
    event         check_ev;
    int           checks;
    int           errors;
    int           test_checks;
    int           test_errors;
    int           num_tests;

    tb_clock clock_gen_i (
        .clk (clk),
        .rst (rst)
    );

    vend_top #(
        .REFUND_TICK (REFUND_TICK)
    ) vend_top_i (
        .clk           (clk),
        .rst           (rst),
        .button_sw     (button_sw),
        .money_display (money_display),
        .stock_1       (stock_1),
        .stock_2       (stock_2),
        .stock_3       (stock_3),
        .selected_item (selected_item),
        .refunding     (refunding),
        .line1_text    (line1_text),
        .line2_text    (line2_text),
        .ddram_address (ddram_address)
    );

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////
    function automatic line_t push_char(input line_t text, input char_t c);
        return {text[LINE_CHARS*CHAR_W-9:0], c};
    endfunction

    // row 0 is the upper line
    function automatic line_t expected_line(input model_t s, input int row);
        int     item;
        line_t  text;
        item = int'(s.window) + row;
        text = '0;
        for (int k = NAME_CHARS - 1; k >= 0; k--) begin
            text = push_char(text, NAME_TEXT[item][k*CHAR_W +: CHAR_W]);
        end
        text = push_char(text, " ");
        text = push_char(text, char_t'(PRICE[item] / 10) + "0");
        text = push_char(text, char_t'(PRICE[item] % 10) + "0");
        text = push_char(text, "0");
        text = push_char(text, "0");
        text = push_char(text, "W");
        text = push_char(text, (s.sel == item_t'(item)) ? "*" : " ");
        text = push_char(text, (s.stock[item] == '0) ? "X" : " ");
        text = push_char(text, (row == 0) ? "^" : "v");
        return text;
    endfunction

    function automatic model_t reset_model();
        model_t s;
        s = '0;
        for (int i = 0; i < NUM_ITEMS; i++) begin
            s.stock[i] = INIT_STOCK[i];
        end
        s.sel   = ITEM_NONE;
        s.addr  = ADDR_LINE1;
        s.line1 = expected_line(s, 0);
        s.line2 = expected_line(s, 1);
        return s;
    endfunction

    // settled state after one press with any refund finished
    function automatic model_t apply_press(input model_t s, input int btn);
        model_t n;
        int     sum;
        n = s;
        case (btn)
            BTN_UP: begin
                if (s.cursor != '0) begin
                    n.cursor = s.cursor - item_t'(1);
                    n.addr   = ADDR_LINE1;
                    n.window = n.cursor[0];
                end
            end
            BTN_DOWN: begin
                if (s.cursor != item_t'(NUM_ITEMS - 1)) begin
                    n.cursor = s.cursor + item_t'(1);
                    n.addr   = ADDR_LINE2;
                    n.window = (n.cursor == item_t'(2));
                end
            end
            BTN_SELECT: begin
                if (s.sel == s.cursor) begin
                    n.sel = ITEM_NONE;
                end else if (s.stock[s.cursor] != '0) begin
                    n.sel = s.cursor;
                end
            end
            BTN_COIN10, BTN_COIN5, BTN_COIN1: begin
                sum       = int'(s.balance) + int'(COIN_VALUE[btn]);
                n.balance = (sum > 255) ? 8'd255 : money_t'(sum);
            end
            BTN_BUY: begin
                if (s.sel != ITEM_NONE && s.stock[s.sel] != '0 && s.balance > PRICE[s.sel]) begin
                    n.balance      = s.balance - PRICE[s.sel];
                    n.stock[s.sel] = s.stock[s.sel] - stock_t'(1);
                    n.sel          = ITEM_NONE;
                end
            end
            BTN_RETURN: n.balance = '0;
            default: n = s;
        endcase
        n.line1 = expected_line(n, 0);
        n.line2 = expected_line(n, 1);
        return n;
    endfunction

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int count, output int value);
        value = 0;
        for (int k = 0; k < count; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // checks and stimulus
    ////////////////////////////////////////////////////////////
    task automatic check_value(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("** Error at %0t ns: %s expected %0d, got %0d", $time, what, exp, got);
        end
    endtask

    task automatic check_line(input string what, input line_t got, input line_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s expected \"%s\", got \"%s\"", $time, what, exp, got);
        end
    endtask

    task automatic compare_now();
        -> check_ev;
        #1;
    endtask

    // one cycle high and four cycles to settle
    task automatic press(input int btn);
        @(posedge clk);
        #1 button_sw[btn] = 1'b1;
        @(posedge clk);
        #1 button_sw[btn] = 1'b0;
        repeat (4) @(posedge clk);
        #1;
    endtask

    // elapsed counts the edges since the return button rose
    task automatic wait_refund_end(input int start_bal, input int elapsed);
        int limit;
        int n;
        limit = start_bal * REFUND_TICK + 4;
        n     = elapsed;
        checks++;
        if (!refunding) begin
            errors++;
            $display("refund did not start at %0t ns with balance %0d", $time, start_bal);
        end
        while (refunding && n < limit) begin
            @(posedge clk);
            #1;
            n++;
        end
        checks++;
        if (refunding) begin
            errors++;
            $display("refund still running %0d cycles after the return press", limit);
        end
    endtask

    task automatic press_and_check(input int btn);
        press(btn);
        if (btn == BTN_RETURN && model.balance != '0) begin
            wait_refund_end(int'(model.balance), PRESS_CYCLES - 1);
        end
        model = apply_press(model, btn);
        compare_now();
    endtask

    task automatic start_test();
        test_checks = checks;
        test_errors = errors;
    endtask

    task automatic finish_test(input string name);
        num_tests++;
        $display("%s: %0d checks, %0d errors", name, checks - test_checks,
                 errors - test_errors);
    endtask

    // compare DUT outputs against the model
    always begin
        @(check_ev);
        check_value("balance", int'(money_display), int'(model.balance));
        check_value("stock 1", int'(stock_1), int'(model.stock[0]));
        check_value("stock 2", int'(stock_2), int'(model.stock[1]));
        check_value("stock 3", int'(stock_3), int'(model.stock[2]));
        check_value("selection", int'(selected_item), int'(model.sel));
        check_value("refunding", int'(refunding), 0);
        check_value("ddram address", int'(ddram_address), int'(model.addr));
        check_line("line 1", line1_text, model.line1);
        check_line("line 2", line2_text, model.line2);
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////
    initial begin
        int start_bal;
        int bal_before;
        int pick;
        button_sw   = '0;
        lfsr_state  = 16'd73;
        checks      = 0;
        errors      = 0;
        num_tests   = 0;
        test_checks = 0;
        test_errors = 0;
        model       = reset_model();
        wait (rst === 1'b1);
        @(posedge clk);
        #1;

        start_test();
        compare_now();
        check_line("reset line 1", line1_text, "1.Coke  1000W  ^");
        check_line("reset line 2", line2_text, "2.Water 1200W  v");
        check_value("reset address", int'(ddram_address), 'h0D);
        finish_test("reset");

        start_test();
        press_and_check(BTN_UP);
        press_and_check(BTN_DOWN);
        press_and_check(BTN_DOWN);
        press_and_check(BTN_DOWN);
        // back to row 1 with the window at 1
        press_and_check(BTN_UP);
        press_and_check(BTN_UP);
        press_and_check(BTN_UP);
        finish_test("cursor and window");

        start_test();
        press_and_check(BTN_SELECT);
        check_value("star on line 1", int'(line1_text[23:16]), int'("*"));
        press_and_check(BTN_SELECT);
        press_and_check(BTN_DOWN);
        press_and_check(BTN_DOWN);
        // juice starts sold out
        press_and_check(BTN_SELECT);
        check_value("sold mark on juice", int'(line2_text[15:8]), int'("X"));
        press_and_check(BTN_UP);
        press_and_check(BTN_UP);
        finish_test("selection");

        start_test();
        press_and_check(BTN_COIN10);
        press_and_check(BTN_SELECT);
        press_and_check(BTN_BUY);
        press_and_check(BTN_COIN5);
        press_and_check(BTN_COIN1);
        press_and_check(BTN_BUY);
        press_and_check(BTN_DOWN);
        press_and_check(BTN_SELECT);
        press_and_check(BTN_COIN10);
        press_and_check(BTN_BUY);
        check_value("water stock", int'(stock_2), 0);
        check_value("sold mark on water", int'(line2_text[15:8]), int'("X"));
        press_and_check(BTN_UP);
        finish_test("coins and purchase");

        start_test();
        press_and_check(BTN_COIN10);
        start_bal = int'(model.balance);
        press(BTN_RETURN);
        bal_before = int'(money_display);
        press(BTN_COIN10);
        checks++;
        if (int'(money_display) > bal_before) begin
            errors++;
            $display("** Error at %0t ns: coin taken during refund, balance %0d after %0d",
                     $time, money_display, bal_before);
        end
        wait_refund_end(start_bal, 2 * PRESS_CYCLES - 1);
        model = apply_press(model, BTN_RETURN);
        compare_now();
        finish_test("refund");

        start_test();
        for (int i = 0; i < RANDOM_PRESSES; i++) begin
            take_bits(4, pick);
            press_and_check(RANDOM_BUTTONS[pick]);
        end
        finish_test("random presses");

        $display("%0d tests, %0d checks, %0d errors", num_tests, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== vend_buttons.sv ====
`timescale 1ns/1ns

module vend_buttons (
    input  logic        clk,
    input  logic        rst,
    input  logic [11:0] button_sw,
    output logic        up_pulse,
    output logic        down_pulse,
    output logic        select_pulse,
    output logic [2:0]  coin_pulse,
    output logic        buy_pulse,
    output logic        return_pulse
);

    // buttons in use, highest priority on the left
    logic [7:0] level;
    logic [7:0] level_q;
    logic [7:0] rise;

    assign level = {button_sw[10], button_sw[4], button_sw[7], button_sw[0],
                    button_sw[1], button_sw[2], button_sw[9], button_sw[3]};
    assign rise  = level & ~level_q;

    always_ff @(posedge clk) begin
        if (!rst) begin
            level_q      <= '0;
            up_pulse     <= 1'b0;
            down_pulse   <= 1'b0;
            select_pulse <= 1'b0;
            coin_pulse   <= '0;
            buy_pulse    <= 1'b0;
            return_pulse <= 1'b0;
        end else begin
            level_q <= level;
            // one command per cycle, the rest are dropped
            up_pulse     <= rise[7];
            down_pulse   <= ~rise[7] & rise[6];
            select_pulse <= ~|rise[7:6] & rise[5];
            coin_pulse   <= '0;
            if (!(|rise[7:5])) begin
                if (rise[4])      coin_pulse <= 3'b001;
                else if (rise[3]) coin_pulse <= 3'b010;
                else if (rise[2]) coin_pulse <= 3'b100;
            end
            buy_pulse    <= ~|rise[7:2] & rise[1];
            return_pulse <= ~|rise[7:1] & rise[0];
        end
    end

endmodule

// ==== vend_credit.sv ====
`timescale 1ns/1ns

module vend_credit import vend_pkg::*; #(
    parameter int REFUND_TICK = 1000000
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [2:0]            coin_pulse,
    input  logic                  buy_pulse,
    input  logic                  return_pulse,
    input  item_t                 selected_item,
    output money_t                money_display,
    output stock_t                stock_1,
    output stock_t                stock_2,
    output stock_t                stock_3,
    output logic [NUM_ITEMS-1:0]  in_stock,
    output logic                  vend_pulse,
    output logic                  refunding
);

    localparam logic [31:0] TICK_LAST = 32'(REFUND_TICK - 1);

    stock_t      stock [NUM_ITEMS];
    money_t      balance;
    money_t      coin_value;
    logic [8:0]  coin_sum;
    money_t      sel_price;
    logic        sel_valid;
    logic [31:0] tick_cnt;
    logic        tick_done;

    ////////////////////////////////////////////////////////////
    // coin value and purchase decision
    ////////////////////////////////////////////////////////////
    always_comb begin
        coin_value = '0;
        // lowest button wins if more than one is set
        for (int i = NUM_ITEMS - 1; i >= 0; i--) begin
            if (coin_pulse[i]) begin
                coin_value = COIN_VALUE[i];
            end
        end
    end

    assign coin_sum = {1'b0, balance} + {1'b0, coin_value};

    always_comb begin
        for (int i = 0; i < NUM_ITEMS; i++) begin
            in_stock[i] = (stock[i] != '0);
        end
    end

    always_comb begin
        sel_valid = 1'b0;
        sel_price = '0;
        if (selected_item != ITEM_NONE) begin
            sel_valid = in_stock[selected_item];
            sel_price = PRICE[selected_item];
        end
    end

    // balance must exceed the price, equal is refused
    assign vend_pulse = buy_pulse & sel_valid & ~refunding & (balance > sel_price);
    assign tick_done  = (tick_cnt == TICK_LAST);

    ////////////////////////////////////////////////////////////
    // balance, stock and refund countdown
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst) begin
            balance   <= '0;
            refunding <= 1'b0;
            tick_cnt  <= '0;
            for (int i = 0; i < NUM_ITEMS; i++) begin
                stock[i] <= INIT_STOCK[i];
            end
        end else if (refunding) begin
            // one unit back per tick, coins and buys locked out
            if (tick_done) begin
                tick_cnt <= '0;
                balance  <= balance - money_t'(1);
                if (balance == money_t'(1)) begin
                    refunding <= 1'b0;
                end
            end else begin
                tick_cnt <= tick_cnt + 32'd1;
            end
        end else if (vend_pulse) begin
            balance              <= balance - sel_price;
            stock[selected_item] <= stock[selected_item] - stock_t'(1);
        end else if (coin_pulse != '0) begin
            // saturate at 255
            balance <= coin_sum[8] ? '1 : coin_sum[7:0];
        end else if (return_pulse && balance != '0) begin
            refunding <= 1'b1;
            tick_cnt  <= '0;
        end
    end

    assign money_display = balance;
    assign stock_1       = stock[0];
    assign stock_2       = stock[1];
    assign stock_3       = stock[2];

endmodule

// ==== vend_lcd_text.sv ====
`timescale 1ns/1ns

module vend_lcd_text import vend_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  window_top,
    input  item_t                 selected_item,
    input  logic [NUM_ITEMS-1:0]  in_stock,
    output line_t                 line1_text,
    output line_t                 line2_text
);

    item_t                 line1_item;
    item_t                 line2_item;
    logic [NUM_ITEMS-1:0]  reset_in_stock;

    ////////////////////////////////////////////////////////////
    // one text line
    ////////////////////////////////////////////////////////////
    // layout: name(7) space price(2) "00W" star sold arrow
    function automatic line_t build_line(
        input item_t                item,
        input item_t                sel,
        input logic [NUM_ITEMS-1:0] stock_ok,
        input char_t                arrow
    );
        money_t price;
        line_t  text;
        price        = PRICE[item];
        text[127:72] = NAME_TEXT[item];
        text[71:64]  = CHAR_SPACE;
        // two price digits
        text[63:56]  = CHAR_ZERO + char_t'(price / money_t'(10));
        text[55:48]  = CHAR_ZERO + char_t'(price % money_t'(10));
        text[47:24]  = {CHAR_ZERO, CHAR_ZERO, CHAR_WON};
        text[23:16]  = (item == sel) ? CHAR_STAR : CHAR_SPACE;
        text[15:8]   = stock_ok[item] ? CHAR_SPACE : CHAR_SOLD;
        text[7:0]    = arrow;
        return text;
    endfunction

    // line 2 always shows the item after line 1
    assign line1_item = {1'b0, window_top};
    assign line2_item = {1'b0, window_top} + item_t'(1);

    always_comb begin
        for (int i = 0; i < NUM_ITEMS; i++) begin
            reset_in_stock[i] = (INIT_STOCK[i] != '0);
        end
    end

    ////////////////////////////////////////////////////////////
    // registered lines
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst) begin
            // window 0, nothing selected, initial stock
            line1_text <= build_line(item_t'(0), ITEM_NONE, reset_in_stock, CHAR_UP);
            line2_text <= build_line(item_t'(1), ITEM_NONE, reset_in_stock, CHAR_DOWN);
        end else begin
            line1_text <= build_line(line1_item, selected_item, in_stock, CHAR_UP);
            line2_text <= build_line(line2_item, selected_item, in_stock, CHAR_DOWN);
        end
    end

endmodule

// ==== vend_pkg.sv ====
package vend_pkg;

    ////////////////////////////////////////////////////////////
    // widths and counts
    ////////////////////////////////////////////////////////////
    localparam int NUM_ITEMS  = 3;
    localparam int ITEM_W     = 2;
    localparam int MONEY_W    = 8;
    localparam int STOCK_W    = 3;
    localparam int CHAR_W     = 8;
    localparam int LINE_CHARS = 16;
    localparam int NAME_CHARS = 7;
    localparam int ADDR_W     = 7;

    typedef logic [ITEM_W-1:0]            item_t;
    typedef logic [MONEY_W-1:0]           money_t;
    typedef logic [STOCK_W-1:0]           stock_t;
    typedef logic [CHAR_W-1:0]            char_t;
    typedef logic [LINE_CHARS*CHAR_W-1:0] line_t;

    // index 3 marks an empty selection
    localparam item_t ITEM_NONE = 2'd3;

    ////////////////////////////////////////////////////////////
    // products and coins
    ////////////////////////////////////////////////////////////
    // prices in units of 100
    localparam money_t PRICE      [NUM_ITEMS] = '{8'd10, 8'd12, 8'd15};
    localparam stock_t INIT_STOCK [NUM_ITEMS] = '{3'd4, 3'd1, 3'd0};
    // coin buttons 0, 1, 2
    localparam money_t COIN_VALUE [NUM_ITEMS] = '{8'd10, 8'd5, 8'd1};

    localparam logic [NAME_CHARS*CHAR_W-1:0] NAME_TEXT [NUM_ITEMS] =
        '{"1.Coke ", "2.Water", "3.Juice"};

    ////////////////////////////////////////////////////////////
    // display codes
    ////////////////////////////////////////////////////////////
    localparam logic [ADDR_W-1:0] ADDR_LINE1 = 7'h0D;
    localparam logic [ADDR_W-1:0] ADDR_LINE2 = 7'h4D;

    localparam char_t CHAR_SPACE = 8'h20;
    localparam char_t CHAR_ZERO  = 8'h30;
    localparam char_t CHAR_WON   = 8'h57;
    localparam char_t CHAR_STAR  = 8'h2A;
    localparam char_t CHAR_SOLD  = 8'h58;
    localparam char_t CHAR_UP    = 8'h5E;
    localparam char_t CHAR_DOWN  = 8'h76;

endpackage

// ==== vend_select.sv ====
`timescale 1ns/1ns

module vend_select import vend_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  up_pulse,
    input  logic                  down_pulse,
    input  logic                  select_pulse,
    input  logic                  vend_pulse,
    input  logic [NUM_ITEMS-1:0]  in_stock,
    output item_t                 selected_item,
    output logic                  window_top,
    output logic [ADDR_W-1:0]     ddram_address
);

    localparam item_t LAST_ROW = item_t'(NUM_ITEMS - 1);

    // cursor row doubles as the item under the cursor
    item_t cursor_row;

    ////////////////////////////////////////////////////////////
    // cursor and scrolling window
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst) begin
            cursor_row    <= '0;
            window_top    <= 1'b0;
            ddram_address <= ADDR_LINE1;
        end else if (up_pulse) begin
            if (cursor_row != '0) begin
                cursor_row    <= cursor_row - item_t'(1);
                ddram_address <= ADDR_LINE1;
                // cursor lands on line 1, so it becomes the top item
                window_top    <= (cursor_row == 2'd2);
            end
        end else if (down_pulse) begin
            if (cursor_row != LAST_ROW) begin
                cursor_row    <= cursor_row + item_t'(1);
                ddram_address <= ADDR_LINE2;
                // cursor lands on line 2, old row stays on top
                window_top    <= (cursor_row == 2'd1);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // selection toggle
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst) begin
            selected_item <= ITEM_NONE;
        end else if (vend_pulse) begin
            // purchase taken
            selected_item <= ITEM_NONE;
        end else if (select_pulse) begin
            if (selected_item == cursor_row) begin
                selected_item <= ITEM_NONE;
            end else if (in_stock[cursor_row]) begin
                selected_item <= cursor_row;
            end
        end
    end

endmodule

// ==== vend_top.sv ====
`timescale 1ns/1ns

module vend_top import vend_pkg::*; #(
    parameter int REFUND_TICK = 1000000
) (
    input  logic               clk,
    input  logic               rst,
    input  logic [11:0]        button_sw,
    output money_t             money_display,
    output stock_t             stock_1,
    output stock_t             stock_2,
    output stock_t             stock_3,
    output item_t              selected_item,
    output logic               refunding,
    output line_t              line1_text,
    output line_t              line2_text,
    output logic [ADDR_W-1:0]  ddram_address
);

    // command pulses
    logic                  up_pulse;
    logic                  down_pulse;
    logic                  select_pulse;
    logic [2:0]            coin_pulse;
    logic                  buy_pulse;
    logic                  return_pulse;

    // credit to select and text
    logic [NUM_ITEMS-1:0]  in_stock;
    logic                  vend_pulse;
    logic                  window_top;

    ////////////////////////////////////////////////////////////
    // command decode
    ////////////////////////////////////////////////////////////
    vend_buttons vend_buttons_i (
        .clk          (clk),
        .rst          (rst),
        .button_sw    (button_sw),
        .up_pulse     (up_pulse),
        .down_pulse   (down_pulse),
        .select_pulse (select_pulse),
        .coin_pulse   (coin_pulse),
        .buy_pulse    (buy_pulse),
        .return_pulse (return_pulse)
    );

    vend_select vend_select_i (
        .clk           (clk),
        .rst           (rst),
        .up_pulse      (up_pulse),
        .down_pulse    (down_pulse),
        .select_pulse  (select_pulse),
        .vend_pulse    (vend_pulse),
        .in_stock      (in_stock),
        .selected_item (selected_item),
        .window_top    (window_top),
        .ddram_address (ddram_address)
    );

    ////////////////////////////////////////////////////////////
    // money, stock and display
    ////////////////////////////////////////////////////////////
    vend_credit #(
        .REFUND_TICK (REFUND_TICK)
    ) vend_credit_i (
        .clk           (clk),
        .rst           (rst),
        .coin_pulse    (coin_pulse),
        .buy_pulse     (buy_pulse),
        .return_pulse  (return_pulse),
        .selected_item (selected_item),
        .money_display (money_display),
        .stock_1       (stock_1),
        .stock_2       (stock_2),
        .stock_3       (stock_3),
        .in_stock      (in_stock),
        .vend_pulse    (vend_pulse),
        .refunding     (refunding)
    );

    vend_lcd_text vend_lcd_text_i (
        .clk           (clk),
        .rst           (rst),
        .window_top    (window_top),
        .selected_item (selected_item),
        .in_stock      (in_stock),
        .line1_text    (line1_text),
        .line2_text    (line2_text)
    );

endmodule
